// File: files.f
+incdir+rtl
rtl/radio_ctrl_pkg.sv
rtl/ctrl_regs.sv
rtl/adc_capture.sv
rtl/led_pwm.sv
rtl/irq_ctrl.sv
rtl/radio_ctrl_top.sv
tb/tb_radio_ctrl.sv

// File: Bender.yml
package:
  name: radio_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/radio_ctrl_pkg.sv
      - rtl/ctrl_regs.sv
      - rtl/adc_capture.sv
      - rtl/led_pwm.sv
      - rtl/irq_ctrl.sv
      - rtl/radio_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_radio_ctrl.sv

// File: tb/tb_radio_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "radio_ctrl_macros.svh"

module tb_radio_ctrl;

    localparam int BUF_DEPTH  = 1 << `RC_BUF_ADDR_W;
    localparam int LED_PERIOD = 1 << `RC_LED_W;

    typedef struct packed
    {
        logic                      is_write;
        radio_ctrl_pkg::reg_addr_t addr;
        radio_ctrl_pkg::reg_data_t data;
        radio_ctrl_pkg::reg_data_t expected; // Read rows only
    } reg_row_t;

    logic                        led_clk;
    logic                        adc_dpram_rst;
    radio_ctrl_pkg::reg_addr_t   reg_addr;
    radio_ctrl_pkg::reg_data_t   reg_wr_data;
    logic                        reg_wr_en;
    logic                        reg_rd_en;
    radio_ctrl_pkg::adc_sample_t adc_data;
    logic                        adc_of;
    radio_ctrl_pkg::reg_data_t   reg_rd_data;
    logic                        red_led;
    logic                        green_led;
    logic                        blue_led;
    logic                        smc_irq_n;
    logic                        dsp_irq_n;

    int unsigned cycle_count;
    int unsigned timeout_limit;
    int          pass_count;
    int          fail_count;
    logic [15:0] adc_lfsr;
    logic [15:0] duty_lfsr;
    reg_row_t    reg_table[$];

    radio_ctrl_top i_radio_ctrl_top
    (
        .led_clk      (led_clk),
        .adc_dpram_rst(adc_dpram_rst),
        .reg_addr     (reg_addr),
        .reg_wr_data  (reg_wr_data),
        .reg_wr_en    (reg_wr_en),
        .reg_rd_en    (reg_rd_en),
        .adc_data     (adc_data),
        .adc_of       (adc_of),
        .reg_rd_data  (reg_rd_data),
        .red_led      (red_led),
        .green_led    (green_led),
        .blue_led     (blue_led),
        .smc_irq_n    (smc_irq_n),
        .dsp_irq_n    (dsp_irq_n)
    );

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hB400;
        else
            return state >> 1;
    endfunction

    always #20 led_clk = ~led_clk;

    // ADC model: counting code, random overflow
    always @(posedge led_clk)
    begin
        adc_data <= adc_data + 1'b1;
        adc_of   <= adc_lfsr[0];
        adc_lfsr <= lfsr_next(adc_lfsr);
    end

    always @(posedge led_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("run did not finish within %0d cycles", timeout_limit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            pass_count = pass_count + 1;
        else
        begin
            fail_count = fail_count + 1;
            $display("error %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic add_write(input radio_ctrl_pkg::reg_addr_t addr,
                             input radio_ctrl_pkg::reg_data_t data);
        reg_table.push_back({1'b1, addr, data, 32'd0});
    endtask

    task automatic add_read(input radio_ctrl_pkg::reg_addr_t addr,
                            input radio_ctrl_pkg::reg_data_t expected);
        reg_table.push_back({1'b0, addr, 32'd0, expected});
    endtask

    task automatic reg_write(input radio_ctrl_pkg::reg_addr_t addr,
                             input radio_ctrl_pkg::reg_data_t data);
        @(posedge led_clk);
        reg_addr    <= addr;
        reg_wr_data <= data;
        reg_wr_en   <= 1'b1;
        @(posedge led_clk);
        reg_wr_en   <= 1'b0;
    endtask

    task automatic reg_read(input radio_ctrl_pkg::reg_addr_t addr,
                            output radio_ctrl_pkg::reg_data_t data);
        @(posedge led_clk);
        reg_addr  <= addr;
        reg_rd_en <= 1'b1;
        @(posedge led_clk);
        reg_rd_en <= 1'b0;
        @(negedge led_clk); // Read word settled after the strobe edge
        data = reg_rd_data;
    endtask

    task automatic draw_duty(output radio_ctrl_pkg::led_duty_t duty);
        duty = '0;
        for (int i = 0; i < `RC_LED_W; i++)
        begin
            duty      = {duty[`RC_LED_W-2:0], duty_lfsr[0]};
            duty_lfsr = lfsr_next(duty_lfsr);
        end
    endtask

    task automatic count_led_high(input int cycles, output int red_cnt,
                                  output int green_cnt, output int blue_cnt);
        red_cnt   = 0;
        green_cnt = 0;
        blue_cnt  = 0;
        repeat (cycles)
        begin
            @(negedge led_clk);
            red_cnt   = red_cnt + red_led;
            green_cnt = green_cnt + green_led;
            blue_cnt  = blue_cnt + blue_led;
        end
    endtask

    // Poll the capturing flag through its rise and fall
    task automatic wait_capture();
        radio_ctrl_pkg::reg_data_t rd;
        rd = '0;
        while (!rd[2])
        begin
            reg_read(`RC_REG_ADC_BUF_CNTRL, rd);
        end
        while (rd[2])
        begin
            reg_read(`RC_REG_ADC_BUF_CNTRL, rd);
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, fail_count - fails_before);
    endtask

    initial
    begin
        radio_ctrl_pkg::reg_data_t rd;
        radio_ctrl_pkg::led_duty_t duty [3];
        logic [15:0]               next_code;
        int                        cnt_r;
        int                        cnt_g;
        int                        cnt_b;
        int                        fails_before;

        led_clk       = 1'b0;
        adc_dpram_rst = 1'b1;
        reg_addr      = '0;
        reg_wr_data   = '0;
        reg_wr_en     = 1'b0;
        reg_rd_en     = 1'b0;
        adc_data      = '0;
        adc_of        = 1'b0;
        adc_lfsr      = 16'd9489;
        duty_lfsr     = 16'd9489;
        cycle_count   = 0;
        pass_count    = 0;
        fail_count    = 0;

        add_read(`RC_REG_ID, `RC_ID_VALUE);
        add_read(`RC_REG_RST_CNTRL, 32'h81); // Both soft resets set
        add_read(`RC_REG_IRQ_CNTRL_STATUS, 32'h0);
        add_read(`RC_REG_LED_CNTRL, 32'h0);
        add_read(`RC_REG_RED_LED_DUTY, 32'h0);
        add_read(`RC_REG_ADC_BUF_CNTRL, 32'h0);
        add_read(`RC_REG_ADC_BUF_ADDR, 32'h0);
        add_write(`RC_REG_RED_LED_DUTY, 32'h0000_0123);
        add_read(`RC_REG_RED_LED_DUTY, 32'h0000_0123);
        add_write(`RC_REG_GREEN_LED_DUTY, 32'hABCD_E456);
        add_read(`RC_REG_GREEN_LED_DUTY, 32'h0000_0456); // Upper bits dropped
        add_write(`RC_REG_BLUE_LED_DUTY, 32'h0000_0FFF);
        add_read(`RC_REG_BLUE_LED_DUTY, 32'h0000_0FFF);
        add_write(`RC_REG_LED_CNTRL, 32'hFFFF_FFFF);
        add_read(`RC_REG_LED_CNTRL, 32'h0000_0007);
        add_write(`RC_REG_IRQ_CNTRL_STATUS, 32'h0000_A55A);
        add_read(`RC_REG_IRQ_CNTRL_STATUS, 32'h0000_A55A);
        add_write(`RC_REG_IRQ_CNTRL_STATUS, 32'h0);
        add_write(`RC_REG_LED_CNTRL, 32'h0);
        add_write(`RC_REG_ADC_BUF_ADDR, 32'h0000_0ABC);
        add_read(`RC_REG_ADC_BUF_ADDR, 32'h0000_0ABC);
        add_read(7'h03, 32'h0);
        add_read(7'h7F, 32'h0);

        // Table, three captures, four PWM periods and margin
        timeout_limit = reg_table.size() * 4 + 3 * BUF_DEPTH + 4 * LED_PERIOD + 200;

        repeat (5) @(posedge led_clk);
        adc_dpram_rst <= 1'b0;

        fails_before = fail_count;
        foreach (reg_table[i])
        begin
            if (reg_table[i].is_write)
                reg_write(reg_table[i].addr, reg_table[i].data);
            else
            begin
                reg_read(reg_table[i].addr, rd);
                check_value("reg_rd_data", reg_table[i].expected, rd);
            end
        end
        report_test("register table", fails_before);

        fails_before = fail_count;
        reg_write(`RC_REG_RST_CNTRL, 32'h80); // Capture released, LED still held
        reg_write(`RC_REG_ADC_BUF_CNTRL, 32'h3); // Trigger with auto-increment
        wait_capture();
        reg_write(`RC_REG_ADC_BUF_ADDR, 32'h0);
        next_code = '0;
        for (int i = 0; i < BUF_DEPTH; i++)
        begin
            reg_read(`RC_REG_ADC_BUF_DATA, rd);
            if (i > 0)
                check_value("reg_rd_data[15:0]", next_code, rd[15:0]);
            next_code = rd[15:0] + 16'd1;
        end
        reg_read(`RC_REG_ADC_BUF_ADDR, rd); // Both addresses back at 0
        check_value("reg_rd_data", 32'h0, rd);
        report_test("capture", fails_before);

        fails_before = fail_count;
        draw_duty(duty[0]);
        draw_duty(duty[1]);
        draw_duty(duty[2]);
        reg_write(`RC_REG_RED_LED_DUTY, duty[0]);
        reg_write(`RC_REG_GREEN_LED_DUTY, duty[1]);
        reg_write(`RC_REG_BLUE_LED_DUTY, duty[2]);
        reg_write(`RC_REG_LED_CNTRL, 32'h7);
        reg_write(`RC_REG_RST_CNTRL, 32'h00);
        repeat (8) @(posedge led_clk);
        count_led_high(LED_PERIOD, cnt_r, cnt_g, cnt_b);
        check_value("red_led high cycles", duty[0], cnt_r);
        check_value("green_led high cycles", duty[1], cnt_g);
        check_value("blue_led high cycles", duty[2], cnt_b);
        reg_write(`RC_REG_LED_CNTRL, 32'h0);
        count_led_high(LED_PERIOD, cnt_r, cnt_g, cnt_b);
        check_value("red_led high cycles", 32'h0, cnt_r);
        check_value("green_led high cycles", 32'h0, cnt_g);
        check_value("blue_led high cycles", 32'h0, cnt_b);
        report_test("led pwm", fails_before);

        fails_before = fail_count;
        reg_write(`RC_REG_IRQ_CNTRL_STATUS, 32'h00FF_0201); // Masks on lines 0 and 1
        repeat (2) @(posedge led_clk);
        @(negedge led_clk);
        check_value("smc_irq_n", 32'h1, smc_irq_n);
        check_value("dsp_irq_n", 32'h1, dsp_irq_n);
        reg_write(`RC_REG_ADC_BUF_CNTRL, 32'h1);
        wait_capture();
        @(negedge led_clk);
        check_value("smc_irq_n", 32'h0, smc_irq_n);
        check_value("dsp_irq_n", 32'h0, dsp_irq_n);
        reg_read(`RC_REG_IRQ_CNTRL_STATUS, rd);
        check_value("irq_state[1:0]", 32'h3, rd[17:16]);
        reg_write(`RC_REG_IRQ_CNTRL_STATUS, 32'h0003_0201);
        repeat (2) @(posedge led_clk);
        @(negedge led_clk);
        check_value("smc_irq_n", 32'h1, smc_irq_n);
        check_value("dsp_irq_n", 32'h1, dsp_irq_n);
        reg_write(`RC_REG_IRQ_CNTRL_STATUS, 32'h2000_2001); // Set line 5, mask1 on line 5
        repeat (2) @(posedge led_clk);
        @(negedge led_clk);
        check_value("smc_irq_n", 32'h1, smc_irq_n);
        check_value("dsp_irq_n", 32'h0, dsp_irq_n);
        report_test("irq", fails_before);

        fails_before = fail_count;
        reg_write(`RC_REG_RST_CNTRL, 32'h80);
        reg_write(`RC_REG_LED_CNTRL, 32'h7);
        reg_write(`RC_REG_RED_LED_DUTY, 32'hFFF);
        reg_write(`RC_REG_GREEN_LED_DUTY, 32'hFFF);
        reg_write(`RC_REG_BLUE_LED_DUTY, 32'hFFF);
        count_led_high(LED_PERIOD / 4, cnt_r, cnt_g, cnt_b);
        check_value("red_led high cycles", 32'h0, cnt_r);
        check_value("green_led high cycles", 32'h0, cnt_g);
        check_value("blue_led high cycles", 32'h0, cnt_b);
        report_test("led soft reset", fails_before);

        $display("checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/radio_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_top
(
    input  wire                         led_clk,
    input  wire                         adc_dpram_rst,
    input  radio_ctrl_pkg::reg_addr_t   reg_addr,
    input  radio_ctrl_pkg::reg_data_t   reg_wr_data,
    input  wire                         reg_wr_en,
    input  wire                         reg_rd_en,
    input  radio_ctrl_pkg::adc_sample_t adc_data,
    input  wire                         adc_of,
    output radio_ctrl_pkg::reg_data_t   reg_rd_data,
    output logic                        red_led,
    output logic                        green_led,
    output logic                        blue_led,
    output logic                        smc_irq_n,
    output logic                        dsp_irq_n
);

    // Capture buffer control and status
    logic                      cap_rst;
    logic                      cap_trig;
    logic                      capturing;
    logic                      adc_of_reg;
    radio_ctrl_pkg::buf_addr_t buf_rd_addr;
    radio_ctrl_pkg::buf_addr_t buf_wr_addr;
    radio_ctrl_pkg::adc_word_t buf_rd_word;

    // LED settings
    logic                      led_rst;
    radio_ctrl_pkg::led_vec_t  led_en;
    radio_ctrl_pkg::led_duty_t red_duty;
    radio_ctrl_pkg::led_duty_t green_duty;
    radio_ctrl_pkg::led_duty_t blue_duty;

    // IRQ control
    radio_ctrl_pkg::irq_vec_t  irq_mask_smc;
    radio_ctrl_pkg::irq_vec_t  irq_mask_dsp;
    radio_ctrl_pkg::irq_vec_t  irq_clear;
    radio_ctrl_pkg::irq_vec_t  irq_set;
    radio_ctrl_pkg::irq_vec_t  irq_state;

    ctrl_regs i_ctrl_regs
    (
        .led_clk      (led_clk),
        .adc_dpram_rst(adc_dpram_rst),
        .reg_addr     (reg_addr),
        .reg_wr_data  (reg_wr_data),
        .reg_wr_en    (reg_wr_en),
        .reg_rd_en    (reg_rd_en),
        .capturing    (capturing),
        .buf_wr_addr  (buf_wr_addr),
        .buf_rd_word  (buf_rd_word),
        .irq_state    (irq_state),
        .reg_rd_data  (reg_rd_data),
        .cap_rst      (cap_rst),
        .cap_trig     (cap_trig),
        .buf_rd_addr  (buf_rd_addr),
        .led_rst      (led_rst),
        .led_en       (led_en),
        .red_duty     (red_duty),
        .green_duty   (green_duty),
        .blue_duty    (blue_duty),
        .irq_mask_smc (irq_mask_smc),
        .irq_mask_dsp (irq_mask_dsp),
        .irq_clear    (irq_clear),
        .irq_set      (irq_set)
    );

    adc_capture i_adc_capture
    (
        .led_clk    (led_clk),
        .cap_rst    (cap_rst),
        .adc_data   (adc_data),
        .adc_of     (adc_of),
        .cap_trig   (cap_trig),
        .buf_rd_addr(buf_rd_addr),
        .capturing  (capturing),
        .buf_wr_addr(buf_wr_addr),
        .buf_rd_word(buf_rd_word),
        .adc_of_reg (adc_of_reg)
    );

    led_pwm i_led_pwm
    (
        .led_clk   (led_clk),
        .led_rst   (led_rst),
        .led_en    (led_en),
        .red_duty  (red_duty),
        .green_duty(green_duty),
        .blue_duty (blue_duty),
        .red_led   (red_led),
        .green_led (green_led),
        .blue_led  (blue_led)
    );

    irq_ctrl i_irq_ctrl
    (
        .led_clk      (led_clk),
        .adc_dpram_rst(adc_dpram_rst),
        .capturing    (capturing),
        .adc_of_reg   (adc_of_reg),
        .irq_mask_smc (irq_mask_smc),
        .irq_mask_dsp (irq_mask_dsp),
        .irq_clear    (irq_clear),
        .irq_set      (irq_set),
        .irq_state    (irq_state),
        .smc_irq_n    (smc_irq_n),
        .dsp_irq_n    (dsp_irq_n)
    );

endmodule

`default_nettype wire

// File: rtl/irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "radio_ctrl_macros.svh"

module irq_ctrl
(
    input  wire                      led_clk,
    input  wire                      adc_dpram_rst,
    input  wire                      capturing,
    input  wire                      adc_of_reg,
    input  radio_ctrl_pkg::irq_vec_t irq_mask_smc,
    input  radio_ctrl_pkg::irq_vec_t irq_mask_dsp,
    input  radio_ctrl_pkg::irq_vec_t irq_clear,
    input  radio_ctrl_pkg::irq_vec_t irq_set,
    output radio_ctrl_pkg::irq_vec_t irq_state,
    output logic                     smc_irq_n,
    output logic                     dsp_irq_n
);

    radio_ctrl_pkg::irq_vec_t irq_lines;
    radio_ctrl_pkg::irq_vec_t irq_lines_d; // Previous cycle for edge detect
    radio_ctrl_pkg::irq_vec_t irq_rise;

    // Lines 0 to 2 are capture running, capture done and ADC overflow
    assign irq_lines = {{(`RC_IRQ_COUNT - 3){1'b0}}, adc_of_reg, ~capturing, capturing};

    assign irq_rise = irq_lines & ~irq_lines_d;

    // Active low requests
    assign smc_irq_n = ~|(irq_state & irq_mask_smc);
    assign dsp_irq_n = ~|(irq_state & irq_mask_dsp);

    // Loads during reset too, so no edge shows up once reset ends
    always_ff @(posedge led_clk)
    begin
        irq_lines_d <= irq_lines;
    end

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
            irq_state <= '0;
        else
            irq_state <= (irq_state & ~irq_clear) | irq_rise | irq_set; // Set beats clear
    end

    // A low output needs a masked source that was pending one edge earlier
    smc_irq_cause: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
        !smc_irq_n |-> |(irq_mask_smc & $past(irq_state | irq_rise | irq_set)))
        else $error("smc_irq_n low without a pending masked source");

    dsp_irq_cause: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
        !dsp_irq_n |-> |(irq_mask_dsp & $past(irq_state | irq_rise | irq_set)))
        else $error("dsp_irq_n low without a pending masked source");

endmodule

`default_nettype wire

// File: rtl/led_pwm.sv
`timescale 1ns/1ps
`default_nettype none

`include "radio_ctrl_macros.svh"

module led_pwm
(
    input  wire                       led_clk,
    input  wire                       led_rst,
    input  radio_ctrl_pkg::led_vec_t  led_en,
    input  radio_ctrl_pkg::led_duty_t red_duty,
    input  radio_ctrl_pkg::led_duty_t green_duty,
    input  radio_ctrl_pkg::led_duty_t blue_duty,
    output logic                      red_led,
    output logic                      green_led,
    output logic                      blue_led
);

    radio_ctrl_pkg::led_duty_t led_cnt; // Shared free-running count
    radio_ctrl_pkg::led_duty_t led_duty [`RC_LED_COUNT];
    radio_ctrl_pkg::led_vec_t  led_status;

    assign led_duty[0] = red_duty;
    assign led_duty[1] = green_duty;
    assign led_duty[2] = blue_duty;

    // Outputs are forced off while held in reset
    assign red_led   = led_status[0] & led_en[0] & ~led_rst;
    assign green_led = led_status[1] & led_en[1] & ~led_rst;
    assign blue_led  = led_status[2] & led_en[2] & ~led_rst;

    always_ff @(posedge led_clk)
    begin
        if (led_rst)
            led_cnt <= '0;
        else
            led_cnt <= led_cnt + 1'b1; // Period of 4096
    end

    for (genvar i = 0; i < `RC_LED_COUNT; i++)
    begin : g_channel
        always_ff @(posedge led_clk)
        begin
            if (led_rst)
                led_status[i] <= 1'b0;
            else if (led_duty[i] == '0)
                led_status[i] <= 1'b0; // Zero duty keeps the channel dark
            else if (led_cnt == '0)
                led_status[i] <= 1'b1;
            else if (led_cnt == led_duty[i])
                led_status[i] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/adc_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "radio_ctrl_macros.svh"

module adc_capture
(
    input  wire                         led_clk,
    input  wire                         cap_rst,
    input  radio_ctrl_pkg::adc_sample_t adc_data,
    input  wire                         adc_of,
    input  wire                         cap_trig,
    input  radio_ctrl_pkg::buf_addr_t   buf_rd_addr,
    output logic                        capturing,
    output radio_ctrl_pkg::buf_addr_t   buf_wr_addr,
    output radio_ctrl_pkg::adc_word_t   buf_rd_word,
    output logic                        adc_of_reg
);

    radio_ctrl_pkg::capture_state_t state;
    radio_ctrl_pkg::adc_word_t      adc_word; // Registered ADC input

    // Sample buffer, one word per address
    radio_ctrl_pkg::adc_word_t mem [0:(1 << `RC_BUF_ADDR_W) - 1];

    assign capturing = (state == radio_ctrl_pkg::cap_writing);

    // Input register
    always_ff @(posedge led_clk)
    begin
        adc_word <= {adc_of, adc_data};
    end

    // Overflow flag also feeds the IRQ controller
    always_ff @(posedge led_clk)
    begin
        if (cap_rst)
            adc_of_reg <= 1'b0;
        else
            adc_of_reg <= adc_of;
    end

    always_ff @(posedge led_clk)
    begin
        if (cap_rst)
        begin
            state       <= radio_ctrl_pkg::cap_idle;
            buf_wr_addr <= '0;
        end
        else
        begin
            case (state)
                radio_ctrl_pkg::cap_idle:
                begin
                    buf_wr_addr <= '0;
                    if (cap_trig)
                        state <= radio_ctrl_pkg::cap_writing;
                end
                radio_ctrl_pkg::cap_writing:
                begin
                    buf_wr_addr <= buf_wr_addr + 1'b1; // Wraps to 0 after last word
                    if (&buf_wr_addr)
                        state <= radio_ctrl_pkg::cap_idle;
                end
                default: state <= radio_ctrl_pkg::cap_idle;
            endcase
        end
    end

    // RAM write port
    always_ff @(posedge led_clk)
    begin
        if (capturing)
            mem[buf_wr_addr] <= adc_word;
    end

    // RAM read port, one cycle latency
    always_ff @(posedge led_clk)
    begin
        buf_rd_word <= mem[buf_rd_addr];
    end

    // The host sees address 0 whenever no capture runs
    idle_addr_zero: assert property (@(posedge led_clk) disable iff (cap_rst)
        (state == radio_ctrl_pkg::cap_idle) |-> (buf_wr_addr == '0))
        else $error("buf_wr_addr not 0 in cap_idle");

endmodule

`default_nettype wire

// File: rtl/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "radio_ctrl_macros.svh"

module ctrl_regs
(
    input  wire                         led_clk,
    input  wire                         adc_dpram_rst,
    input  radio_ctrl_pkg::reg_addr_t   reg_addr,
    input  radio_ctrl_pkg::reg_data_t   reg_wr_data,
    input  wire                         reg_wr_en,
    input  wire                         reg_rd_en,
    input  wire                         capturing,
    input  radio_ctrl_pkg::buf_addr_t   buf_wr_addr,
    input  radio_ctrl_pkg::adc_word_t   buf_rd_word,
    input  radio_ctrl_pkg::irq_vec_t    irq_state,
    output radio_ctrl_pkg::reg_data_t   reg_rd_data,
    output logic                        cap_rst,
    output logic                        cap_trig,
    output radio_ctrl_pkg::buf_addr_t   buf_rd_addr,
    output logic                        led_rst,
    output radio_ctrl_pkg::led_vec_t    led_en,
    output radio_ctrl_pkg::led_duty_t   red_duty,
    output radio_ctrl_pkg::led_duty_t   green_duty,
    output radio_ctrl_pkg::led_duty_t   blue_duty,
    output radio_ctrl_pkg::irq_vec_t    irq_mask_smc,
    output radio_ctrl_pkg::irq_vec_t    irq_mask_dsp,
    output radio_ctrl_pkg::irq_vec_t    irq_clear,
    output radio_ctrl_pkg::irq_vec_t    irq_set
);

    logic cap_soft_rst;
    logic led_soft_rst;
    logic buf_rd_inc; // Read address auto-increment

    // Block resets: external reset or host soft reset
    assign cap_rst = adc_dpram_rst | cap_soft_rst;
    assign led_rst = adc_dpram_rst | led_soft_rst;

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
        begin
            cap_soft_rst <= 1'b1;
            led_soft_rst <= 1'b1;
            irq_mask_smc <= '0;
            irq_mask_dsp <= '0;
            irq_clear    <= '0;
            irq_set      <= '0;
            led_en       <= '0;
            red_duty     <= '0;
            green_duty   <= '0;
            blue_duty    <= '0;
            cap_trig     <= 1'b0;
            buf_rd_inc   <= 1'b0;
            buf_rd_addr  <= '0;
            reg_rd_data  <= '0;
        end
        else
        begin
            // Drop requests that have already taken effect
            irq_clear <= irq_state & irq_clear;
            irq_set   <= ~irq_state & irq_set;
            cap_trig  <= ~capturing & cap_trig; // Sequencer has started

            if (reg_wr_en)
            begin
                case (reg_addr)
                    `RC_REG_RST_CNTRL:
                    begin
                        cap_soft_rst <= reg_wr_data[0];
                        led_soft_rst <= reg_wr_data[7];
                    end
                    `RC_REG_IRQ_CNTRL_STATUS:
                    begin
                        irq_mask_smc <= reg_wr_data[7:0];
                        irq_mask_dsp <= reg_wr_data[15:8];
                        irq_clear    <= reg_wr_data[23:16];
                        irq_set      <= reg_wr_data[31:24];
                    end
                    `RC_REG_LED_CNTRL:      led_en     <= reg_wr_data[2:0];
                    `RC_REG_RED_LED_DUTY:   red_duty   <= reg_wr_data[11:0];
                    `RC_REG_GREEN_LED_DUTY: green_duty <= reg_wr_data[11:0];
                    `RC_REG_BLUE_LED_DUTY:  blue_duty  <= reg_wr_data[11:0];
                    `RC_REG_ADC_BUF_CNTRL:
                    begin
                        cap_trig   <= reg_wr_data[0];
                        buf_rd_inc <= reg_wr_data[1];
                    end
                    `RC_REG_ADC_BUF_ADDR:   buf_rd_addr <= reg_wr_data[`RC_BUF_ADDR_W-1:0];
                    default:
                    begin
                        // ID and data registers are read only
                    end
                endcase
            end

            if (reg_rd_en)
            begin
                case (reg_addr)
                    `RC_REG_ID:               reg_rd_data <= `RC_ID_VALUE;
                    `RC_REG_RST_CNTRL:        reg_rd_data <= {24'd0, led_soft_rst, 6'd0, cap_soft_rst};
                    `RC_REG_IRQ_CNTRL_STATUS: reg_rd_data <= {8'd0, irq_state, irq_mask_dsp, irq_mask_smc};
                    `RC_REG_LED_CNTRL:        reg_rd_data <= radio_ctrl_pkg::reg_data_t'(led_en);
                    `RC_REG_RED_LED_DUTY:     reg_rd_data <= radio_ctrl_pkg::reg_data_t'(red_duty);
                    `RC_REG_GREEN_LED_DUTY:   reg_rd_data <= radio_ctrl_pkg::reg_data_t'(green_duty);
                    `RC_REG_BLUE_LED_DUTY:    reg_rd_data <= radio_ctrl_pkg::reg_data_t'(blue_duty);
                    `RC_REG_ADC_BUF_CNTRL:    reg_rd_data <= {29'd0, capturing, buf_rd_inc, cap_trig};
                    `RC_REG_ADC_BUF_ADDR:
                    begin
                        reg_rd_data <= {{(16 - `RC_BUF_ADDR_W){1'b0}}, buf_wr_addr,
                                        {(16 - `RC_BUF_ADDR_W){1'b0}}, buf_rd_addr};
                    end
                    `RC_REG_ADC_BUF_DATA:
                    begin
                        reg_rd_data <= radio_ctrl_pkg::reg_data_t'(buf_rd_word);
                        if (buf_rd_inc)
                            buf_rd_addr <= buf_rd_addr + 1'b1; // Next sample
                    end
                    default:                  reg_rd_data <= '0; // Unmapped
                endcase
            end
        end
    end

    // The strobe bus carries one access per cycle
    host_rd_wr_excl: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
        !(reg_wr_en && reg_rd_en))
        else $error("reg_wr_en and reg_rd_en high together");

endmodule

`default_nettype wire

// File: rtl/radio_ctrl_pkg.sv
`default_nettype none

`include "radio_ctrl_macros.svh"

package radio_ctrl_pkg;

    // Host bus
    typedef logic [6:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // ADC path
    typedef logic [15:0] adc_sample_t;
    typedef logic [16:0] adc_word_t; // Overflow flag on top of the code
    typedef logic [`RC_BUF_ADDR_W-1:0] buf_addr_t;

    typedef logic [`RC_IRQ_COUNT-1:0] irq_vec_t;

    // LED driver
    typedef logic [`RC_LED_W-1:0]     led_duty_t;
    typedef logic [`RC_LED_COUNT-1:0] led_vec_t;

    // Capture sequencer
    typedef enum logic
    {
        cap_idle,
        cap_writing
    } capture_state_t;

endpackage

`default_nettype wire

// File: rtl/radio_ctrl_macros.svh
`ifndef RADIO_CTRL_MACROS_SVH
`define RADIO_CTRL_MACROS_SVH

// Host register map
`define RC_REG_ID                7'h00
`define RC_REG_RST_CNTRL         7'h01
`define RC_REG_IRQ_CNTRL_STATUS  7'h02
`define RC_REG_LED_CNTRL         7'h10
`define RC_REG_RED_LED_DUTY      7'h11
`define RC_REG_GREEN_LED_DUTY    7'h12
`define RC_REG_BLUE_LED_DUTY     7'h13
`define RC_REG_ADC_BUF_CNTRL     7'h20
`define RC_REG_ADC_BUF_ADDR      7'h21
`define RC_REG_ADC_BUF_DATA      7'h22

`define RC_ID_VALUE              32'hDADC0001 // Identity word

// Capture buffer depth is 2^12 samples
`define RC_BUF_ADDR_W            12

`define RC_IRQ_COUNT             8

// PWM resolution and channel count
`define RC_LED_W                 12
`define RC_LED_COUNT             3

`endif
